/* build.f */
rtl/dsi_pkg.sv
rtl/ecc_calc.sv
rtl/crc_calculator.sv
rtl/packet_framer.sv
rtl/lane_write_ctrl.sv
rtl/packets_assembler.sv
tests/packets_assembler_tb.sv

/* rtl/crc_calculator.sv */
module crc_calculator
    import dsi_pkg::*;
(
    input  logic        clk,
    input  logic        reset_stop_read_data_hs,
    input  logic        clear,
    input  logic        update,
    input  byte_count_t bytes_number,
    input  data_word_t  data_input,
    output crc_t        crc_output_async,
    output crc_t        crc_output_sync
);

    crc_t crc_reg;
    crc_t crc_next;

    // one byte through the reflected crc, lsb of the byte goes in first
    function automatic crc_t crc_byte(crc_t crc_in, logic [7:0] data);
        crc_t crc;
        crc = crc_in;
        for (int b = 0; b < 8; b++)
        begin
            if (crc[0] ^ data[b])
                crc = (crc >> 1) ^ CRC_POLY_REFLECTED;
            else
                crc = crc >> 1;
        end
        return crc;
    endfunction

    // byte 0 of the word is the oldest byte on the link
    always_comb
    begin
        crc_next = crc_reg;
        for (int i = 0; i < BYTES_PER_WORD; i++)
        begin
            if (byte_count_t'(i) < bytes_number)
                crc_next = crc_byte(crc_next, data_input[8*i +: 8]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_stop_read_data_hs || clear)
            crc_reg <= CRC_INIT;
        else if (update)
            crc_reg <= crc_next;
    end

    assign crc_output_async = crc_next;  // already includes the presented word
    assign crc_output_sync  = crc_reg;

endmodule

/* rtl/dsi_pkg.sv */
package dsi_pkg;

    typedef logic [31:0] data_word_t;   // fifo word, lanes controller word and internal words
    typedef logic [7:0]  data_id_t;     // data identifier of a dsi packet
    typedef logic [15:0] word_count_t;  // payload byte count of a long packet
    typedef logic [7:0]  ecc_t;         // header ecc, top two bits stay zero
    typedef logic [15:0] crc_t;
    typedef logic [2:0]  byte_count_t;  // valid bytes in a word, 0 to 4
    typedef logic [3:0]  strobe_t;

    localparam byte_count_t BYTES_PER_WORD = 3'd4;
    localparam byte_count_t CRC_BYTES      = 3'd2;

    // dsi crc16 runs lsb first, so the polynomial is kept in reflected form
    localparam crc_t CRC_INIT           = 16'hFFFF;
    localparam crc_t CRC_POLY_REFLECTED = 16'h8408;

    typedef enum logic [1:0]
    {
        FR_HEADER,
        FR_PAYLOAD,
        FR_CRC_TAIL
    } framer_state_t;

    typedef enum logic
    {
        WR_IDLE,
        WR_BURST
    } write_state_t;

endpackage

/* rtl/ecc_calc.sv */
module ecc_calc
    import dsi_pkg::*;
(
    input  logic [23:0] header,
    output ecc_t        ecc
);

    // header bits covered by each parity bit of the dsi hamming code
    localparam logic [23:0] P0_MASK = 24'hF12CB7;
    localparam logic [23:0] P1_MASK = 24'hF2555B;
    localparam logic [23:0] P2_MASK = 24'h749A6D;
    localparam logic [23:0] P3_MASK = 24'hB8E38E;
    localparam logic [23:0] P4_MASK = 24'hDF03F0;
    localparam logic [23:0] P5_MASK = 24'hEFFC00;

    logic [5:0] parity;

    assign parity[0] = ^(header & P0_MASK);
    assign parity[1] = ^(header & P1_MASK);
    assign parity[2] = ^(header & P2_MASK);
    assign parity[3] = ^(header & P3_MASK);
    assign parity[4] = ^(header & P4_MASK);
    assign parity[5] = ^(header & P5_MASK);

    assign ecc = {2'b00, parity};   // bits 7:6 are reserved and sent as zero

endmodule

/* rtl/lane_write_ctrl.sv */
module lane_write_ctrl
    import dsi_pkg::*;
(
    input  logic        clk,
    input  logic        reset_stop_read_data_hs,
    input  data_word_t  word_data,
    input  byte_count_t word_bytes,
    input  logic        word_last,
    input  logic        word_avail,
    output logic        read_data,
    input  logic        iface_data_rqst,
    input  logic        user_cmd_transmission_mode,
    output data_word_t  iface_write_data,
    output strobe_t     iface_write_strb,
    output logic        iface_write_rqst,
    output logic        iface_last_word,
    output logic        iface_lpm_en
);

    write_state_t state;
    strobe_t      strobe_next;
    logic         fill_pipe;       // header fetch that opens a burst
    logic         last_consumed;

    assign fill_pipe     = (state == WR_IDLE) && word_avail;
    assign last_consumed = (state == WR_BURST) && iface_data_rqst && iface_last_word;

    // in a burst the next word is fetched when the presented one is taken
    assign read_data = fill_pipe
                    || ((state == WR_BURST) && iface_data_rqst && !iface_last_word);

    always_comb
    begin
        case (word_bytes)
            3'd0:    strobe_next = 4'b0000;
            3'd1:    strobe_next = 4'b0001;
            3'd2:    strobe_next = 4'b0011;
            3'd3:    strobe_next = 4'b0111;
            3'd4:    strobe_next = 4'b1111;
            default: strobe_next = 4'b0000;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset_stop_read_data_hs)
            state <= WR_IDLE;
        else if (fill_pipe)
            state <= WR_BURST;
        else if (last_consumed)
            state <= WR_IDLE;
    end

    always_ff @(posedge clk)
    begin
        if (reset_stop_read_data_hs)
            iface_write_rqst <= 1'b0;
        else
            iface_write_rqst <= fill_pipe;  // high only in the cycle after the header fetch
    end

    always_ff @(posedge clk)
    begin
        if (reset_stop_read_data_hs)
        begin
            iface_write_data <= '0;
            iface_write_strb <= '0;
            iface_last_word  <= 1'b0;
        end
        else if (read_data)
        begin
            iface_write_data <= word_data;
            iface_write_strb <= strobe_next;
            iface_last_word  <= word_last;
        end
        else if (last_consumed)
        begin
            iface_write_data <= '0;
            iface_write_strb <= '0;
            iface_last_word  <= 1'b0;
        end
    end

    // lp/hs choice is taken at the header fetch and held until the burst is over
    always_ff @(posedge clk)
    begin
        if (reset_stop_read_data_hs)
            iface_lpm_en <= 1'b0;
        else if (state == WR_IDLE)
            iface_lpm_en <= user_cmd_transmission_mode;
    end

endmodule

/* rtl/packet_framer.sv */
module packet_framer
    import dsi_pkg::*;
(
    input  logic        clk,
    input  logic        reset_stop_read_data_hs,
    input  data_word_t  usr_fifo_data,
    input  logic        usr_fifo_empty,
    output logic        usr_fifo_read,
    input  logic        read_data,
    output data_word_t  word_data,
    output byte_count_t word_bytes,
    output logic        word_last,
    output logic        word_avail
);

    framer_state_t state;
    word_count_t   bytes_left;      // payload bytes not yet sent
    data_id_t      data_id;
    word_count_t   word_count;
    ecc_t          header_ecc;
    logic          packet_long;
    logic          last_payload;
    logic          crc_fits;
    logic          fifo_pop;
    byte_count_t   payload_bytes;
    byte_count_t   tail_bytes;
    data_word_t    payload_masked;
    data_word_t    crc_merged;
    data_word_t    tail_word;
    crc_t          crc_async;
    crc_t          crc_sync;
    logic          crc_clear;
    logic          crc_update;

    assign data_id    = usr_fifo_data[7:0];
    assign word_count = usr_fifo_data[23:8];

    // long packets have bit 3 set and a non-zero low field, the rest are short
    assign packet_long = data_id[3] && (|data_id[2:0]);

    ecc_calc ecc_0
    (
        .header (usr_fifo_data[23:0]),
        .ecc    (header_ecc)
    );

    assign last_payload  = (bytes_left <= word_count_t'(BYTES_PER_WORD));
    assign payload_bytes = last_payload ? byte_count_t'(bytes_left) : BYTES_PER_WORD;

    // both crc bytes still fit behind the final payload bytes
    assign crc_fits = (bytes_left <= word_count_t'(BYTES_PER_WORD - CRC_BYTES));

    // bytes past the end of the payload must go out as zero
    always_comb
    begin
        payload_masked = '0;
        for (int i = 0; i < BYTES_PER_WORD; i++)
        begin
            if (byte_count_t'(i) < payload_bytes)
                payload_masked[8*i +: 8] = usr_fifo_data[8*i +: 8];
        end
    end

    // crc bytes that do not fit are shifted out of the word here
    assign crc_merged = last_payload ? (data_word_t'(crc_async) << {payload_bytes, 3'b000})
                                     : '0;

    // bytes_left still holds 3 or 4 here, which tells how much crc is left
    assign tail_bytes = byte_count_t'(bytes_left) - (BYTES_PER_WORD - CRC_BYTES);
    assign tail_word  = data_word_t'(crc_sync) >> {CRC_BYTES - tail_bytes, 3'b000};

    always_comb
    begin
        case (state)
            FR_HEADER:
            begin
                word_data  = {header_ecc, usr_fifo_data[23:0]};  // ecc replaces bits 31:24
                word_bytes = BYTES_PER_WORD;
                word_last  = !packet_long;
                word_avail = !usr_fifo_empty;
                fifo_pop   = 1'b1;
            end
            FR_PAYLOAD:
            begin
                word_data  = payload_masked | crc_merged;
                word_bytes = crc_fits ? (payload_bytes + CRC_BYTES) : BYTES_PER_WORD;
                word_last  = crc_fits;
                word_avail = (bytes_left == '0) || !usr_fifo_empty;  // an empty payload needs no fifo word
                fifo_pop   = (bytes_left != '0);
            end
            FR_CRC_TAIL:
            begin
                word_data  = tail_word;
                word_bytes = tail_bytes;
                word_last  = 1'b1;
                word_avail = 1'b1;
                fifo_pop   = 1'b0;
            end
            default:
            begin
                word_data  = '0;
                word_bytes = '0;
                word_last  = 1'b0;
                word_avail = 1'b0;
                fifo_pop   = 1'b0;
            end
        endcase
    end

    assign usr_fifo_read = read_data && fifo_pop && !usr_fifo_empty;

    assign crc_clear  = read_data && (state == FR_HEADER);
    assign crc_update = read_data && (state == FR_PAYLOAD);

    crc_calculator crc_0
    (
        .clk                     (clk),
        .reset_stop_read_data_hs (reset_stop_read_data_hs),
        .clear                   (crc_clear),
        .update                  (crc_update),
        .bytes_number            (payload_bytes),
        .data_input              (payload_masked),
        .crc_output_async        (crc_async),
        .crc_output_sync         (crc_sync)
    );

    always_ff @(posedge clk)
    begin
        if (reset_stop_read_data_hs)
        begin
            state      <= FR_HEADER;
            bytes_left <= '0;
        end
        else if (read_data)
        begin
            case (state)
                FR_HEADER:
                begin
                    if (packet_long)
                    begin
                        bytes_left <= word_count;
                        state      <= FR_PAYLOAD;
                    end
                end
                FR_PAYLOAD:
                begin
                    if (crc_fits)
                        state <= FR_HEADER;
                    else if (last_payload)
                        state <= FR_CRC_TAIL;  // keep bytes_left to size the tail word
                    else
                        bytes_left <= bytes_left - word_count_t'(BYTES_PER_WORD);
                end
                FR_CRC_TAIL:
                    state <= FR_HEADER;
                default:
                    state <= FR_HEADER;
            endcase
        end
    end

endmodule

/* rtl/packets_assembler.sv */
module packets_assembler
    import dsi_pkg::*;
(
    input  logic       clk,
    input  logic       reset_stop_read_data_hs,

    input  data_word_t usr_fifo_data,
    input  logic       usr_fifo_empty,
    output logic       usr_fifo_read,

    input  logic       user_cmd_transmission_mode,  // 1 sends user commands in lp mode

    input  logic       iface_data_rqst,
    output data_word_t iface_write_data,
    output strobe_t    iface_write_strb,
    output logic       iface_write_rqst,
    output logic       iface_last_word,
    output logic       iface_lpm_en
);

    data_word_t  word_data;
    byte_count_t word_bytes;
    logic        word_last;
    logic        word_avail;
    logic        read_data;

    packet_framer framer_0
    (
        .clk                     (clk),
        .reset_stop_read_data_hs (reset_stop_read_data_hs),
        .usr_fifo_data           (usr_fifo_data),
        .usr_fifo_empty          (usr_fifo_empty),
        .usr_fifo_read           (usr_fifo_read),
        .read_data               (read_data),
        .word_data               (word_data),
        .word_bytes              (word_bytes),
        .word_last               (word_last),
        .word_avail              (word_avail)
    );

    // the write side only moves words, packet boundaries come from word_last
    lane_write_ctrl write_ctrl_0
    (
        .clk                        (clk),
        .reset_stop_read_data_hs    (reset_stop_read_data_hs),
        .word_data                  (word_data),
        .word_bytes                 (word_bytes),
        .word_last                  (word_last),
        .word_avail                 (word_avail),
        .read_data                  (read_data),
        .iface_data_rqst            (iface_data_rqst),
        .user_cmd_transmission_mode (user_cmd_transmission_mode),
        .iface_write_data           (iface_write_data),
        .iface_write_strb           (iface_write_strb),
        .iface_write_rqst           (iface_write_rqst),
        .iface_last_word            (iface_last_word),
        .iface_lpm_en               (iface_lpm_en)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# builds and runs the packets assembler testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module packets_assembler_tb -f build.f \
    -o packets_sim > compile.log 2>&1 \
    && ./obj_dir/packets_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see compile.log and sim.log"; exit 1; }

grep -q "test failed" sim.log && { echo "simulation reported a failure"; exit 1; } \
    || { echo "simulation finished without failures"; exit 0; }

/* tests/packets_assembler_tb.sv */
module packets_assembler_tb
    import dsi_pkg::*;
();

    localparam int STIM_WORDS   = 86;
    localparam int WORD_TIMEOUT = 40;
    localparam int TIMEOUT_BASE = 200;
    localparam int RESET_CYCLES = 10;

    logic       clk;
    logic       reset_stop_read_data_hs;
    data_word_t usr_fifo_data;
    logic       usr_fifo_empty;
    logic       usr_fifo_read;
    logic       user_cmd_transmission_mode;
    logic       iface_data_rqst;
    data_word_t iface_write_data;
    strobe_t    iface_write_strb;
    logic       iface_write_rqst;
    logic       iface_last_word;
    logic       iface_lpm_en;

    data_word_t stim_mem [0:STIM_WORDS-1];
    int value_errors = 0;
    int other_errors = 0;
    int fifo_errors  = 0;
    int cycle_count  = 0;
    int cycle_limit  = 1000000;  // replaced once the stimulus is read
    int pop_total    = 0;

    packets_assembler dut
    (
        .clk                        (clk),
        .reset_stop_read_data_hs    (reset_stop_read_data_hs),
        .usr_fifo_data              (usr_fifo_data),
        .usr_fifo_empty             (usr_fifo_empty),
        .usr_fifo_read              (usr_fifo_read),
        .user_cmd_transmission_mode (user_cmd_transmission_mode),
        .iface_data_rqst            (iface_data_rqst),
        .iface_write_data           (iface_write_data),
        .iface_write_strb           (iface_write_strb),
        .iface_write_rqst           (iface_write_rqst),
        .iface_last_word            (iface_last_word),
        .iface_lpm_en               (iface_lpm_en)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // fifo pops are counted here, the head word is driven from the count at the falling edge
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (usr_fifo_read)
        begin
            if (usr_fifo_empty)
            begin
                $display("FIFO was popped while empty at time %0t", $time);
                fifo_errors++;
            end
            pop_total <= pop_total + 1;
        end
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("errors: %0d wrong values, %0d other failures", value_errors,
                     other_errors + fifo_errors + 1);
            $display("test failed");
            $finish;
        end
    end

    task automatic check_idle_outputs();
        if (iface_write_rqst !== 1'b0 || iface_last_word !== 1'b0 || iface_lpm_en !== 1'b0 ||
            usr_fifo_read !== 1'b0 || iface_write_strb !== 4'b0000 ||
            iface_write_data !== 32'h0)
        begin
            $display("Error at %0t: outputs not idle around reset", $time);
            value_errors++;
        end
    endtask

    // one block of the stimulus file, the lanes controller side is modelled cycle by cycle
    task automatic run_block(input int base, input bit random_gaps, output int next_base);
        bit         mode;
        int         n_fifo;
        int         n_exp;
        int         fifo_base;
        int         exp_base;
        int         exp_idx;
        int         pop_start;
        int         pops;
        int         bursts;
        int         lasts;
        int         idle_cycles;
        int         i;
        bit         active;
        bit         prev_active;
        bit         prev_rqst;
        bit         prev_wrq;
        data_word_t held_data;
        strobe_t    held_strb;
        bit         held_last;
        data_word_t exp_data;
        strobe_t    exp_strb;
        bit         exp_last;

        mode      = stim_mem[base][0];
        n_fifo    = stim_mem[base + 1];
        n_exp     = stim_mem[base + 2];
        fifo_base = base + 3;
        exp_base  = fifo_base + n_fifo;
        next_base = exp_base + 3 * n_exp;
        lasts     = 0;
        for (i = 0; i < n_exp; i++)
        begin
            if (stim_mem[exp_base + 3 * i + 2][0])
                lasts++;
        end
        pop_start   = pop_total;
        exp_idx     = 0;
        bursts      = 0;
        active      = 1'b0;
        prev_active = 1'b0;
        prev_rqst   = 1'b0;
        prev_wrq    = 1'b0;
        idle_cycles = 0;
        held_data   = '0;
        held_strb   = '0;
        held_last   = 1'b0;

        @(negedge clk);
        user_cmd_transmission_mode = mode;
        while (idle_cycles < 4)
        begin
            pops           = pop_total - pop_start;
            usr_fifo_data  = (pops < n_fifo) ? stim_mem[fifo_base + pops] : 32'h0;
            usr_fifo_empty = (pops >= n_fifo);
            if (iface_write_rqst)
            begin
                if (prev_wrq)
                begin
                    $display("write request stayed high for more than one cycle");
                    other_errors++;
                end
                else if (active)
                begin
                    $display("a new burst started before the last word was taken");
                    other_errors++;
                end
                bursts++;
                active = 1'b1;
            end
            prev_wrq        = iface_write_rqst;
            iface_data_rqst = 1'b0;
            if (active)
            begin
                if (iface_lpm_en !== mode)
                begin
                    $display("Error at %0t: lpm enable %b, expected %b", $time, iface_lpm_en, mode);
                    value_errors++;
                end
                if (prev_active && !prev_rqst && (iface_write_data !== held_data ||
                    iface_write_strb !== held_strb || iface_last_word !== held_last))
                begin
                    $display("Error at %0t: presented word changed without a request", $time);
                    value_errors++;
                end
                held_data = iface_write_data;
                held_strb = iface_write_strb;
                held_last = iface_last_word;
                // the mode may wander inside a burst but is back in place for the next one
                if (iface_last_word)
                    user_cmd_transmission_mode = mode;
                else if (random_gaps)
                    user_cmd_transmission_mode = ($urandom % 2) == 1;
                iface_data_rqst = random_gaps ? (($urandom % 3) != 0) : 1'b1;
                if (iface_data_rqst)
                begin
                    if (exp_idx >= n_exp)
                    begin
                        $display("the DUT sent more words than the packets hold");
                        other_errors++;
                    end
                    else
                    begin
                        exp_data = stim_mem[exp_base + 3 * exp_idx];
                        exp_strb = stim_mem[exp_base + 3 * exp_idx + 1][3:0];
                        exp_last = stim_mem[exp_base + 3 * exp_idx + 2][0];
                        if (iface_write_data !== exp_data || iface_write_strb !== exp_strb ||
                            iface_last_word !== exp_last)
                        begin
                            $display("Error at %0t: word %0d is %h/%b/%b, expected %h/%b/%b",
                                     $time, exp_idx, iface_write_data, iface_write_strb,
                                     iface_last_word, exp_data, exp_strb, exp_last);
                            value_errors++;
                        end
                    end
                    exp_idx++;
                    if (iface_last_word)
                        active = 1'b0;  // consuming the last word closes the burst
                end
            end
            prev_rqst   = iface_data_rqst;
            prev_active = active;
            if (!active && exp_idx >= n_exp)
                idle_cycles++;
            @(negedge clk);
        end
        iface_data_rqst = 1'b0;
        usr_fifo_empty  = 1'b1;

        if (pop_total - pop_start != n_fifo)
        begin
            $display("FIFO popped %0d times, expected %0d", pop_total - pop_start, n_fifo);
            other_errors++;
        end
        if (bursts != lasts)
        begin
            $display("saw %0d bursts where %0d packets were loaded", bursts, lasts);
            other_errors++;
        end
    endtask

    initial
    begin
        int base;
        int next_base;
        int pass_index;
        int total_exp;
        int seed_value;

        reset_stop_read_data_hs    = 1'b1;
        usr_fifo_data              = 32'h0;
        usr_fifo_empty             = 1'b1;
        user_cmd_transmission_mode = 1'b0;
        iface_data_rqst            = 1'b0;
        seed_value = $urandom(32'h9bdb);

        $readmemh("tests/packets_stim.txt", stim_mem);
        total_exp = 0;
        base      = 0;
        while (stim_mem[base + 1] != 32'h0)
        begin
            total_exp = total_exp + stim_mem[base + 2];
            base      = base + 3 + stim_mem[base + 1] + 3 * stim_mem[base + 2];
        end
        cycle_limit = WORD_TIMEOUT * total_exp * 2 + TIMEOUT_BASE;  // two passes over the file

        repeat (RESET_CYCLES)
        begin
            @(negedge clk);
            check_idle_outputs();
        end
        reset_stop_read_data_hs = 1'b0;
        repeat (3)
        begin
            @(negedge clk);
            check_idle_outputs();
        end

        // first pass takes every word at once, second pass inserts random gaps
        for (pass_index = 0; pass_index < 2; pass_index++)
        begin
            base = 0;
            while (stim_mem[base + 1] != 32'h0)
            begin
                run_block(base, pass_index == 1, next_base);
                base = next_base;
            end
        end

        $display("errors: %0d wrong values, %0d other failures", value_errors,
                 other_errors + fifo_errors);
        if (value_errors + other_errors + fifo_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* tests/packets_stim.txt */
// block: mode, fifo word count, expected word count, the fifo words, then data strobe last per word
// a block with a fifo word count of zero ends the list
1 1 1
AA001105
36001105 f 1
0 1 2
AA000029
1C000029 f 0
0000FFFF 3 1
1 2 2
55000129 DDCCBB01
06000129 f 0
001E0E01 7 1
0 5 6
00000229 DDCC0201 00000329 DD030201 00001105
00000229 f 0
CA720201 f 1
1A000329 f 0
C4030201 f 0
00000062 1 1
36001105 f 1
1 5 7
00000429 04030201 00000729 04030201 EE070605
3F000429 f 0
04030201 f 0
0000C66E 3 1
39000729 f 0
04030201 f 0
FE070605 f 0
00000092 1 1
0 0 0
